// File: hdl/vga_timing_pkg.sv
package vga_timing_pkg;

    ////////////////////////////////////////////////////////////
    // raster and buffer types
    ////////////////////////////////////////////////////////////

    localparam int BUF_INDEX_W = 13;                  // enough for 4800 entries.

    typedef logic [9:0]             pos_t;            // raster or scaled coordinate.
    typedef logic [BUF_INDEX_W-1:0] index_t;          // frame store address.

    ////////////////////////////////////////////////////////////
    // 640x480 raster, counts are inclusive
    ////////////////////////////////////////////////////////////

    localparam pos_t H_DISPLAY       = 10'd640;       // visible pixels per line.
    localparam pos_t V_DISPLAY       = 10'd480;       // visible lines.
    localparam pos_t H_MAX           = 10'd831;       // last horizontal count.
    localparam pos_t V_MAX           = 10'd520;       // lines per frame.
    localparam pos_t START_H_RETRACE = 10'd664;
    localparam pos_t END_H_RETRACE   = 10'd703;
    localparam pos_t START_V_RETRACE = 10'd489;
    localparam pos_t END_V_RETRACE   = 10'd491;

    ////////////////////////////////////////////////////////////
    // down-scaled frame store geometry
    ////////////////////////////////////////////////////////////

    localparam pos_t        SCALE_FACTOR = 10'd8;                    // screen pixels per cell side.
    localparam pos_t        BUF_WIDTH    = H_DISPLAY / SCALE_FACTOR; // 80 cells.
    localparam pos_t        BUF_HEIGHT   = V_DISPLAY / SCALE_FACTOR; // 60 cells.
    localparam int unsigned BUF_DEPTH    = 4800;                     // cells per bank.

endpackage

// File: hdl/vga_bus_pkg.sv
package vga_bus_pkg;

    ////////////////////////////////////////////////////////////
    // store bus
    ////////////////////////////////////////////////////////////

    typedef logic [63:0] addr_t;                      // processor store address.
    typedef logic [31:0] wdata_t;                     // processor store data.

    // the only register the controller answers to.
    localparam addr_t VGA_COLOR_ADDR = 64'h0000_0000_1000_0000;

    ////////////////////////////////////////////////////////////
    // pixel format
    ////////////////////////////////////////////////////////////

    typedef logic [3:0]  channel_t;                   // one colour channel.
    typedef logic [11:0] color_t;                     // {red, green, blue}.

    ////////////////////////////////////////////////////////////
    // data word layout, {y, x, colour}
    ////////////////////////////////////////////////////////////

    localparam int COLOR_LSB = 0;                     // colour in bits 11:0.
    localparam int X_LSB     = 12;                    // scaled x in bits 21:12.
    localparam int Y_LSB     = 22;                    // scaled y in bits 31:22.

endpackage

// File: hdl/vga_write_port.sv
`timescale 1ns/1ps

module vga_write_port (
    input  logic                   rst,
    input  logic                   VGA_clk,
    input  logic                   wr_enable,
    input  vga_bus_pkg::addr_t     addr,
    input  vga_bus_pkg::wdata_t    w_data,
    output logic                   wr_en,
    output vga_timing_pkg::index_t wr_index,
    output vga_bus_pkg::color_t    wr_color,
    output logic                   VGA_taken
);

    logic                   hit;          // store to the colour register.
    logic                   in_range;
    vga_timing_pkg::pos_t   px_x;
    vga_timing_pkg::pos_t   px_y;
    vga_bus_pkg::color_t    px_color;
    vga_timing_pkg::index_t px_index;

    assign hit = wr_enable && (addr == vga_bus_pkg::VGA_COLOR_ADDR);

    // unpack the data word.
    assign px_color = w_data[vga_bus_pkg::COLOR_LSB +: $bits(vga_bus_pkg::color_t)];
    assign px_x     = w_data[vga_bus_pkg::X_LSB +: $bits(vga_timing_pkg::pos_t)];
    assign px_y     = w_data[vga_bus_pkg::Y_LSB +: $bits(vga_timing_pkg::pos_t)];

    assign in_range = (px_x < vga_timing_pkg::BUF_WIDTH) &&
                      (px_y < vga_timing_pkg::BUF_HEIGHT);

    // row-major cell index, y * 80 + x.
    assign px_index = vga_timing_pkg::index_t'(px_y) *
                      vga_timing_pkg::index_t'(vga_timing_pkg::BUF_WIDTH) +
                      vga_timing_pkg::index_t'(px_x);

    always_ff @(posedge rst or posedge VGA_clk) begin
        if (VGA_clk) begin
            wr_en     <= 1'b0;
            VGA_taken <= 1'b0;
        end else begin
            wr_en     <= hit && in_range;   // off-screen pixels are dropped.
            VGA_taken <= hit;               // but still acknowledged.
        end
    end

    always_ff @(posedge rst) begin
        wr_index <= px_index;
        wr_color <= px_color;
    end

endmodule

// File: hdl/vga_frame_store.sv
`timescale 1ns/1ps

module vga_frame_store (
    input  logic                   rst,
    input  logic                   VGA_clk,
    input  logic                   frame_start,
    input  logic                   wr_en,
    input  vga_timing_pkg::index_t wr_index,
    input  vga_bus_pkg::color_t    wr_color,
    input  vga_timing_pkg::index_t rd_index,
    output vga_bus_pkg::color_t    rd_color
);

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    vga_bus_pkg::color_t bank0 [vga_timing_pkg::BUF_DEPTH];
    vga_bus_pkg::color_t bank1 [vga_timing_pkg::BUF_DEPTH];

    // selects the displayed bank, the other one takes writes.
    logic bank_sel;

    ////////////////////////////////////////////////////////////
    // bank swap
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rst or posedge VGA_clk) begin
        if (VGA_clk) begin
            bank_sel <= 1'b0;                   // show bank 0 first.
        end else if (frame_start) begin
            bank_sel <= ~bank_sel;              // once per frame.
        end
    end

    ////////////////////////////////////////////////////////////
    // write and read ports
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rst) begin
        if (wr_en) begin
            if (bank_sel) begin
                bank0[wr_index] <= wr_color;    // bank 1 on screen.
            end else begin
                bank1[wr_index] <= wr_color;    // bank 0 on screen.
            end
        end
    end

    // asynchronous read of the front bank.
    always_comb begin
        if (bank_sel) begin
            rd_color = bank1[rd_index];
        end else begin
            rd_color = bank0[rd_index];
        end
    end

endmodule

// File: hdl/vga_sync_gen.sv
`timescale 1ns/1ps

module vga_sync_gen (
    input  logic                 rst,
    input  logic                 VGA_clk,
    output vga_timing_pkg::pos_t h,
    output vga_timing_pkg::pos_t v,
    output logic                 active,
    output logic                 frame_start,
    output logic                 Hsync,
    output logic                 Vsync
);

    logic h_wrap;   // last count of the line.
    logic v_wrap;   // last line of the frame.

    assign h_wrap = (h == vga_timing_pkg::H_MAX);
    assign v_wrap = (v == vga_timing_pkg::V_MAX - 10'd1);

    ////////////////////////////////////////////////////////////
    // raster counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge rst or posedge VGA_clk) begin
        if (VGA_clk) begin
            h <= '0;
            v <= '0;
        end else begin
            if (h_wrap) begin
                h <= '0;
                if (v_wrap) begin
                    v <= '0;
                end else begin
                    v <= v + 10'd1;
                end
            end else begin
                h <= h + 10'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    // counters sit at zero in reset, so both syncs are low there.
    assign Hsync = (h >= vga_timing_pkg::START_H_RETRACE) &&
                   (h <= vga_timing_pkg::END_H_RETRACE);
    assign Vsync = (v >= vga_timing_pkg::START_V_RETRACE) &&
                   (v <= vga_timing_pkg::END_V_RETRACE);

    assign active = (h < vga_timing_pkg::H_DISPLAY) &&
                    (v < vga_timing_pkg::V_DISPLAY);

    // first cycle of vertical retrace.
    assign frame_start = (h == '0) && (v == vga_timing_pkg::START_V_RETRACE);

endmodule

// File: hdl/vga_scan_out.sv
`timescale 1ns/1ps

module vga_scan_out (
    input  logic                   rst,
    input  logic                   VGA_clk,
    input  vga_timing_pkg::pos_t   h,
    input  vga_timing_pkg::pos_t   v,
    input  logic                   active,
    output vga_timing_pkg::index_t rd_index,
    input  vga_bus_pkg::color_t    rd_color,
    output vga_bus_pkg::channel_t  VGA_r,
    output vga_bus_pkg::channel_t  VGA_g,
    output vga_bus_pkg::channel_t  VGA_b
);

    vga_timing_pkg::pos_t   cell_x;
    vga_timing_pkg::pos_t   cell_y;
    vga_timing_pkg::index_t cell_index;
    vga_bus_pkg::color_t    color_q;    // colour for the previous position.

    // screen position to scaled cell.
    assign cell_x = h / vga_timing_pkg::SCALE_FACTOR;
    assign cell_y = v / vga_timing_pkg::SCALE_FACTOR;

    assign cell_index = vga_timing_pkg::index_t'(cell_y) *
                        vga_timing_pkg::index_t'(vga_timing_pkg::BUF_WIDTH) +
                        vga_timing_pkg::index_t'(cell_x);

    // park on cell 0 outside the window so the read stays in range.
    assign rd_index = active ? cell_index : '0;

    always_ff @(posedge rst or posedge VGA_clk) begin
        if (VGA_clk) begin
            color_q <= '0;
        end else if (active) begin
            color_q <= rd_color;
        end else begin
            color_q <= '0;              // black in blanking.
        end
    end

    assign VGA_r = color_q[11:8];
    assign VGA_g = color_q[7:4];
    assign VGA_b = color_q[3:0];

endmodule

// File: hdl/vga_top.sv
`timescale 1ns/1ps

module vga_top (
    input  logic                  rst,
    input  logic                  VGA_clk,
    input  logic                  wr_enable,
    input  vga_bus_pkg::addr_t    addr,
    input  vga_bus_pkg::wdata_t   w_data,
    output logic                  VGA_taken,
    output logic                  Hsync,
    output logic                  Vsync,
    output vga_bus_pkg::channel_t VGA_r,
    output vga_bus_pkg::channel_t VGA_g,
    output vga_bus_pkg::channel_t VGA_b
);

    ////////////////////////////////////////////////////////////
    // write path
    ////////////////////////////////////////////////////////////

    logic                   wr_en;
    vga_timing_pkg::index_t wr_index;
    vga_bus_pkg::color_t    wr_color;

    vga_write_port u_write_port (
        .rst       (rst),
        .VGA_clk   (VGA_clk),
        .wr_enable (wr_enable),
        .addr      (addr),
        .w_data    (w_data),
        .wr_en     (wr_en),
        .wr_index  (wr_index),
        .wr_color  (wr_color),
        .VGA_taken (VGA_taken)
    );

    ////////////////////////////////////////////////////////////
    // raster path
    ////////////////////////////////////////////////////////////

    vga_timing_pkg::pos_t   h;
    vga_timing_pkg::pos_t   v;
    logic                   active;
    logic                   frame_start;
    vga_timing_pkg::index_t rd_index;
    vga_bus_pkg::color_t    rd_color;

    vga_sync_gen u_sync_gen (
        .rst         (rst),
        .VGA_clk     (VGA_clk),
        .h           (h),
        .v           (v),
        .active      (active),
        .frame_start (frame_start),
        .Hsync       (Hsync),
        .Vsync       (Vsync)
    );

    vga_frame_store u_frame_store (
        .rst         (rst),
        .VGA_clk     (VGA_clk),
        .frame_start (frame_start),   // bank swap.
        .wr_en       (wr_en),
        .wr_index    (wr_index),
        .wr_color    (wr_color),
        .rd_index    (rd_index),
        .rd_color    (rd_color)
    );

    vga_scan_out u_scan_out (
        .rst      (rst),
        .VGA_clk  (VGA_clk),
        .h        (h),
        .v        (v),
        .active   (active),
        .rd_index (rd_index),
        .rd_color (rd_color),
        .VGA_r    (VGA_r),
        .VGA_g    (VGA_g),
        .VGA_b    (VGA_b)
    );

endmodule

// File: testbench/tb_vga.sv
`timescale 1ns/1ps

module tb_vga;

    localparam int LINE_CYCLES   = int'(vga_timing_pkg::H_MAX) + 1;       // 832.
    localparam int FRAME_LINES   = int'(vga_timing_pkg::V_MAX);           // 520.
    localparam int FRAME_CYCLES  = LINE_CYCLES * FRAME_LINES;             // 432640.
    localparam int SCALE         = int'(vga_timing_pkg::SCALE_FACTOR);
    localparam int CELLS_X       = int'(vga_timing_pkg::BUF_WIDTH);
    localparam int CELLS_Y       = int'(vga_timing_pkg::BUF_HEIGHT);
    localparam int DEPTH         = int'(vga_timing_pkg::BUF_DEPTH);
    localparam int SWAP_CYCLE    = int'(vga_timing_pkg::START_V_RETRACE) * LINE_CYCLES;
    localparam int LIMIT_CYCLES  = 4 * FRAME_CYCLES + 10000;

    logic                  rst;        // pixel clock.
    logic                  VGA_clk;    // active-high async reset.
    logic                  wr_enable;
    vga_bus_pkg::addr_t    addr;
    vga_bus_pkg::wdata_t   w_data;
    logic                  VGA_taken;
    logic                  Hsync;
    logic                  Vsync;
    vga_bus_pkg::channel_t VGA_r;
    vga_bus_pkg::channel_t VGA_g;
    vga_bus_pkg::channel_t VGA_b;

    logic [31:0]         lfsr;
    int                  cyc;            // cycles since reset release.
    logic                raster_on;
    vga_bus_pkg::color_t shadow [2][vga_timing_pkg::BUF_DEPTH];   // expected bank contents.

    vga_top u_dut (
        .rst       (rst),
        .VGA_clk   (VGA_clk),
        .wr_enable (wr_enable),
        .addr      (addr),
        .w_data    (w_data),
        .VGA_taken (VGA_taken),
        .Hsync     (Hsync),
        .Vsync     (Vsync),
        .VGA_r     (VGA_r),
        .VGA_g     (VGA_g),
        .VGA_b     (VGA_b)
    );

    initial begin
        rst = 1'b0;
        forever #20 rst = ~rst;                 // 25 MHz.
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic stop_with_error(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // x^32 + x^22 + x^2 + x + 1 feedback polynomial.
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic vga_bus_pkg::wdata_t pack_pixel(input int x, input int y,
                                                       input vga_bus_pkg::color_t c);
        vga_bus_pkg::wdata_t d;
        d = '0;
        d[vga_bus_pkg::Y_LSB +: 10]     = 10'(y);
        d[vga_bus_pkg::X_LSB +: 10]     = 10'(x);
        d[vga_bus_pkg::COLOR_LSB +: 12] = c;
        return d;
    endfunction

    // bank that takes a store registered in the current cycle.
    function automatic logic back_bank();
        int swaps;
        swaps = cyc / FRAME_CYCLES + (((cyc % FRAME_CYCLES) > SWAP_CYCLE) ? 1 : 0);
        return (swaps % 2 == 0) ? 1'b1 : 1'b0;
    endfunction

    task automatic wait_for_cycle(input int target);
        while (cyc < target) begin
            @(negedge rst);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_color(input vga_bus_pkg::color_t expected);
        vga_bus_pkg::color_t observed;
        observed = {VGA_r, VGA_g, VGA_b};
        if (observed !== expected) begin
            stop_with_error($sformatf("colour is %h at cycle %0d, expected %h",
                                      observed, cyc, expected));
        end
    endtask

    task automatic check_level(input logic expected, input string what);
        logic observed;
        observed = (what == "Hsync") ? Hsync : Vsync;
        if (observed !== expected) begin
            stop_with_error($sformatf("%s is %b at cycle %0d, expected %b",
                                      what, observed, cyc, expected));
        end
    endtask

    task automatic check_taken(input logic expected);
        if (VGA_taken !== expected) begin
            stop_with_error($sformatf("VGA_taken is %b, expected %b", VGA_taken, expected));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // raster tracker checks every cycle after release
    ////////////////////////////////////////////////////////////

    task automatic raster_step();
        int                     hh;
        int                     vv;
        int                     p;
        int                     f;
        logic                   known;
        vga_bus_pkg::color_t    exp;
        vga_timing_pkg::index_t idx;
        hh = cyc % LINE_CYCLES;
        vv = (cyc / LINE_CYCLES) % FRAME_LINES;
        check_level(hh >= int'(vga_timing_pkg::START_H_RETRACE) &&
                    hh <= int'(vga_timing_pkg::END_H_RETRACE), "Hsync");
        check_level(vv >= int'(vga_timing_pkg::START_V_RETRACE) &&
                    vv <= int'(vga_timing_pkg::END_V_RETRACE), "Vsync");
        known = 1'b1;
        exp   = '0;
        if (cyc > 0) begin
            p  = cyc - 1;                        // colour lags one cycle.
            hh = p % LINE_CYCLES;
            vv = (p / LINE_CYCLES) % FRAME_LINES;
            f  = p / FRAME_CYCLES;
            if (hh < int'(vga_timing_pkg::H_DISPLAY) && vv < int'(vga_timing_pkg::V_DISPLAY)) begin
                if (f == 0) begin
                    known = 1'b0;                // bank 0 not loaded yet.
                end else begin
                    idx = vga_timing_pkg::index_t'((vv / SCALE) * CELLS_X + hh / SCALE);
                    exp = shadow[(f % 2 == 1) ? 1 : 0][idx];
                end
            end
        end
        if (known) begin
            check_color(exp);
        end
    endtask

    initial begin
        cyc = 0;
        wait (raster_on);
        forever begin
            @(negedge rst);
            raster_step();
            cyc = cyc + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // bus stimulus
    ////////////////////////////////////////////////////////////

    task automatic bus_store(input logic en, input vga_bus_pkg::addr_t a,
                             input vga_bus_pkg::wdata_t d);
        logic hit;
        int   x;
        int   y;
        hit = en && (a == vga_bus_pkg::VGA_COLOR_ADDR);
        x   = int'(d[vga_bus_pkg::X_LSB +: 10]);
        y   = int'(d[vga_bus_pkg::Y_LSB +: 10]);
        @(posedge rst);
        #2;
        wr_enable = en;
        addr      = a;
        w_data    = d;
        @(posedge rst);
        #2;
        wr_enable = 1'b0;
        if (hit && x < CELLS_X && y < CELLS_Y) begin
            shadow[back_bank()][vga_timing_pkg::index_t'(y * CELLS_X + x)] =
                d[vga_bus_pkg::COLOR_LSB +: 12];
        end
        @(negedge rst);
        check_taken(hit);                        // one cycle after the request.
        @(negedge rst);
        check_taken(1'b0);
    endtask

    task automatic clear_back_bank();
        for (int i = 0; i < DEPTH; i++) begin
            bus_store(1'b1, vga_bus_pkg::VGA_COLOR_ADDR, pack_pixel(i % CELLS_X, i / CELLS_X, '0));
        end
    endtask

    task automatic random_pixels(input int count);
        vga_bus_pkg::color_t c;
        int                  x;
        int                  y;
        for (int i = 0; i < count; i++) begin
            x = int'(lfsr_bits(7)) % CELLS_X;
            y = int'(lfsr_bits(6)) % CELLS_Y;
            c = vga_bus_pkg::color_t'(lfsr_bits(12));
            if (c == '0) c = 12'h0f0;
            bus_store(1'b1, vga_bus_pkg::VGA_COLOR_ADDR, pack_pixel(x, y, c));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_state();
        @(posedge rst);
        for (int i = 0; i < 8; i++) begin
            @(negedge rst);
            check_taken(1'b0);
            check_level(1'b0, "Hsync");
            check_level(1'b0, "Vsync");
            check_color('0);
        end
        @(posedge rst);
        #2;
        VGA_clk   = 1'b0;
        raster_on = 1'b1;
        @(negedge rst);
        check_taken(1'b0);                       // sync and colour via the tracker.
    endtask

    // runs in frame 0 while bank 1 takes writes.
    task automatic write_ack();
        clear_back_bank();
        bus_store(1'b1, vga_bus_pkg::VGA_COLOR_ADDR ^ (64'd1 << lfsr_bits(6)),
                  pack_pixel(3, 4, 12'hfff));
        bus_store(1'b1, '0, pack_pixel(5, 6, 12'h00f));
        bus_store(1'b0, vga_bus_pkg::VGA_COLOR_ADDR, pack_pixel(7, 8, 12'hf00));
    endtask

    task automatic pixel_display();
        random_pixels(12);
        wait_for_cycle(FRAME_CYCLES + 8);        // into frame 1.
    endtask

    // runs in frame 1 while bank 0 takes writes.
    task automatic bank_alternation();
        int ox;
        int oy;
        clear_back_bank();
        random_pixels(12);
        ox = CELLS_X + int'(lfsr_bits(6));       // would land on cell (ox - 80, oy + 1).
        oy = int'(lfsr_bits(6)) % (CELLS_Y - 1);
        bus_store(1'b1, vga_bus_pkg::VGA_COLOR_ADDR, pack_pixel(ox, oy, 12'hfff));
        bus_store(1'b1, vga_bus_pkg::VGA_COLOR_ADDR,
                  pack_pixel(int'(lfsr_bits(6)), CELLS_Y + int'(lfsr_bits(2)), 12'h0ff));
        wait_for_cycle(2 * FRAME_CYCLES + int'(vga_timing_pkg::V_DISPLAY) * LINE_CYCLES);
    endtask

    task automatic sync_timing();
        wait_for_cycle(3 * FRAME_CYCLES);        // frame 2 fully traced.
    endtask

    initial begin
        repeat (LIMIT_CYCLES) @(posedge rst);
        $display("Timeout: the run did not finish within %0d clock cycles.", LIMIT_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        VGA_clk        = 1'b1;
        wr_enable      = 1'b0;
        addr           = '0;
        w_data         = '0;
        lfsr           = 32'h0f7cb246;
        raster_on      = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            shadow[0][vga_timing_pkg::index_t'(i)] = '0;
            shadow[1][vga_timing_pkg::index_t'(i)] = '0;
        end
        reset_state();
        write_ack();
        pixel_display();
        bank_alternation();
        sync_timing();
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: flist.f
hdl/vga_timing_pkg.sv
hdl/vga_bus_pkg.sv
hdl/vga_write_port.sv
hdl/vga_frame_store.sv
hdl/vga_sync_gen.sv
hdl/vga_scan_out.sv
hdl/vga_top.sv
testbench/tb_vga.sv

// File: Makefile
# Verilator flow for the VGA controller.

LOG = sim.log

.PHONY: all lint sim clean

all: sim

# lint the synthesizable design only.
lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module vga_top

# build and run the testbench, pass only if the log holds the pass line.
sim:
	verilator --binary --timing -f flist.f --top-module tb_vga \
		--Mdir obj_dir -o sim_vga
	./obj_dir/sim_vga | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
